// ==== verification/routing_core_testdata.txt ====
# W addr data : host write | R addr expected : host read and compare
# S : start and wait for done | T name : closes a test group
W 100 a5a5
W 2fe 1234
W 6fe ffff
R 100 a5a5
R 2fe 1234
R 6fe ffff
T host_rw
# sinks 0x11 and 0x22 with worst hops 3 and 5, three neighbors
W 008 0011
W 00a 0022
W 688 0002
W 028 0003
W 02a 0005
W 68a 0003
W 1c8 0028
W 1ca 000a
W 1cc 000e
W 68e 0008
W 690 0000
W 692 0001
# neighbor 0 row full, neighbor 2 already lists 0x11
W 248 0031
W 24a 0032
W 24c 0033
W 24e 0034
W 250 0035
W 252 0036
W 254 0037
W 256 0038
W 268 0011
S
R 258 0011
R 25a 0022
R 690 0002
R 1ca 0014
R 26a 0022
R 692 0002
R 1cc 0014
T append
R 268 0011
R 248 0031
R 256 0038
R 68e 0008
R 1c8 0028
T skip
R 6c0 0001
T best_hop
S
R 25a 0022
R 690 0002
R 1ca 0014
R 692 0002
R 1c8 0028
R 6c0 0001
T rerun

// ==== sources.f ====
src/routing_pkg.sv
src/table_memory.sv
src/table_arbiter.sv
src/sink_list_fixer.sv
src/next_hop_selector.sv
src/routing_core.sv
verification/routing_core_properties.sv
verification/routing_core_tb.sv

// ==== Makefile ====
all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module routing_core_tb -o Vrouting_core_tb

run: build
	./obj_dir/Vrouting_core_tb | tee sim.log
	@if grep -qF '** FAIL **' sim.log || ! grep -qF '** PASS **' sim.log; then \
		echo "simulation did not pass"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module routing_core_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== verification/routing_core_tb.sv ====
`timescale 1ns/100ps

module routing_core_tb;
	import routing_pkg::*;

	localparam int DONE_TIMEOUT  = 5000; // cycles allowed per start
	localparam int SETTLE_CYCLES = 8; // watch window for a stray done

	logic            clock;
	logic            nrst;
	mem_req_t        host_req;
	word_t           host_rdata;
	logic            start;
	logic            done;
	int              fd;
	logic [7:0]      cmd; // one-letter command
	logic [8*32-1:0] name;
	logic [8*80-1:0] rest;
	word_t           arg_addr;
	word_t           arg_data;
	int              test_errors;
	int              total_errors;
	int              tests_passed;
	int              tests_failed;
	int              starts;
	int              done_count = 0;

	routing_core DUT (
		.clock      (clock),
		.nrst       (nrst),
		.host_req   (host_req),
		.host_rdata (host_rdata),
		.start      (start),
		.done       (done)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		if (nrst && done) begin
			done_count <= done_count + 1;
		end
	end

	task automatic check_value(input string signal, input word_t actual,
			input word_t expected);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, signal,
				actual, expected);
			test_errors++;
		end
	endtask

	// one-cycle host strobe that returns on the next falling edge
	task automatic host_strobe(input logic write, input word_t addr, input word_t data);
		host_req.valid = 1'b1;
		host_req.write = write;
		host_req.addr  = addr_t'(addr);
		host_req.wdata = data;
		@(negedge clock);
		host_req = REQ_IDLE;
	endtask

	task automatic run_engines;
		int cycles;
		cycles = 0;
		start  = 1'b1;
		starts++;
		@(negedge clock);
		start = 1'b0;
		while (!done && cycles < DONE_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!done) begin
			$display("Timeout: done did not arrive within %0d cycles of start",
				DONE_TIMEOUT);
			test_errors++;
		end
		repeat (SETTLE_CYCLES) @(negedge clock);
		check_value("done_count", word_t'(done_count), word_t'(starts));
	endtask

	task automatic finish_test(input logic [8*32-1:0] test_name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("Test %0s: passed", test_name);
		end else begin
			tests_failed++;
			$display("Test %0s: failed with %0d errors", test_name, test_errors);
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		nrst         = 1'b0;
		start        = 1'b0;
		host_req     = REQ_IDLE;
		test_errors  = 0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		starts       = 0;
		repeat (2) @(negedge clock);
		nrst = 1'b1;
		fd = $fopen("verification/routing_core_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file");
			total_errors++;
		end else begin
			while ($fscanf(fd, "%s", cmd) == 1) begin
				case (cmd)
					"#": void'($fgets(rest, fd)); // comment line
					"W": begin
						void'($fscanf(fd, "%h %h", arg_addr, arg_data));
						host_strobe(1'b1, arg_addr, arg_data);
					end
					"R": begin
						void'($fscanf(fd, "%h %h", arg_addr, arg_data));
						host_strobe(1'b0, arg_addr, '0);
						check_value($sformatf("mem[%h]", arg_addr[10:0]), host_rdata,
							arg_data);
					end
					"S": run_engines();
					"T": begin
						void'($fscanf(fd, "%s", name));
						finish_test(name);
					end
					default: begin
						$display("Unknown command %s in the test data file", cmd);
						total_errors++;
					end
				endcase
			end
			$fclose(fd);
		end
		total_errors += test_errors; // checks after the last group
		if (DUT.u_arbiter.props.failures != 0) begin
			$display("Arbiter assertions failed %0d times",
				DUT.u_arbiter.props.failures);
		end
		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (total_errors == 0 && tests_failed == 0 && tests_passed > 0
				&& DUT.u_arbiter.props.failures == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== verification/routing_core_properties.sv ====
`timescale 1ns/100ps

module routing_core_properties (
	input logic                  clock,
	input logic                  nrst,
	input routing_pkg::mem_req_t host_req,
	input routing_pkg::mem_req_t fix_req,
	input routing_pkg::mem_req_t sel_req,
	input logic                  fix_gnt,
	input logic                  sel_gnt,
	input logic                  fix_rvalid,
	input logic                  sel_rvalid,
	input routing_pkg::mem_req_t mem_req
);
	int unsigned failures = 0; // assertion failure count

	grant_onehot: assert property (@(posedge clock) disable iff (!nrst)
		$onehot0({host_req.valid, fix_gnt, sel_gnt}))
	else begin
		failures++;
		$error("more than one requester granted");
	end

	host_wins: assert property (@(posedge clock) disable iff (!nrst)
		host_req.valid |-> mem_req == host_req)
	else begin
		failures++;
		$error("host request did not reach the memory");
	end

	// rvalid exactly one cycle after a granted read reaches the memory
	fix_read_return: assert property (@(posedge clock) disable iff (!nrst)
		fix_rvalid == $past(fix_gnt && mem_req.valid && !mem_req.write))
	else begin
		failures++;
		$error("fixer rvalid out of step with its granted read");
	end

	sel_read_return: assert property (@(posedge clock) disable iff (!nrst)
		sel_rvalid == $past(sel_gnt && mem_req.valid && !mem_req.write))
	else begin
		failures++;
		$error("selector rvalid out of step with its granted read");
	end

endmodule

bind table_arbiter routing_core_properties props (.*);

// ==== src/routing_core.sv ====
`timescale 1ns/100ps

module routing_core #(
	parameter int          MEM_WORDS  = 1024,
	parameter int unsigned SINK_SLOTS = 8
) (
	input  logic                  clock,
	input  logic                  nrst,
	input  routing_pkg::mem_req_t host_req,
	output routing_pkg::word_t    host_rdata,
	input  logic                  start,
	output logic                  done
);
	import routing_pkg::*;

	mem_req_t fix_req;
	mem_req_t sel_req;
	mem_req_t mem_req;
	word_t    mem_rdata; // shared read data for host and engines
	logic     fix_gnt;
	logic     sel_gnt;
	logic     fix_rvalid;
	logic     sel_rvalid;
	logic     fix_done; // kicks off the selector

	assign host_rdata = mem_rdata;

	table_arbiter u_arbiter (
		.clock      (clock),
		.nrst       (nrst),
		.host_req   (host_req),
		.fix_req    (fix_req),
		.sel_req    (sel_req),
		.fix_gnt    (fix_gnt),
		.sel_gnt    (sel_gnt),
		.fix_rvalid (fix_rvalid),
		.sel_rvalid (sel_rvalid),
		.mem_req    (mem_req)
	);

	table_memory #(.MEM_WORDS(MEM_WORDS)) u_memory (
		.clock (clock),
		.req   (mem_req),
		.rdata (mem_rdata)
	);

	sink_list_fixer #(.SINK_SLOTS(SINK_SLOTS)) u_fixer (
		.clock  (clock),
		.nrst   (nrst),
		.start  (start),
		.req    (fix_req),
		.gnt    (fix_gnt),
		.rvalid (fix_rvalid),
		.rdata  (mem_rdata),
		.done   (fix_done)
	);

	next_hop_selector u_selector (
		.clock  (clock),
		.nrst   (nrst),
		.start  (fix_done),
		.req    (sel_req),
		.gnt    (sel_gnt),
		.rvalid (sel_rvalid),
		.rdata  (mem_rdata),
		.done   (done)
	);

endmodule

// ==== src/next_hop_selector.sv ====
`timescale 1ns/100ps

module next_hop_selector (
	input  logic                  clock,
	input  logic                  nrst,
	input  logic                  start,
	output routing_pkg::mem_req_t req,
	input  logic                  gnt,
	input  logic                  rvalid,
	input  routing_pkg::word_t    rdata,
	output logic                  done
);
	import routing_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_NCNT,
		S_Q,
		S_WR,
		S_DONE
	} sel_state_t;

	sel_state_t state;
	logic       rd_wait;
	word_t      i; // neighbor under test
	word_t      ncnt;
	word_t      best_q;
	word_t      best_idx;

	assign done = (state == S_DONE);

	always_comb begin
		req = REQ_IDLE;
		case (state)
			S_NCNT: begin
				req.valid = !rd_wait;
				req.addr  = NEIGHBOR_COUNT_ADDR;
			end
			S_Q: begin
				req.valid = !rd_wait;
				req.addr  = table_addr(Q_VALUE_BASE, i);
			end
			S_WR: begin
				req.valid = 1'b1;
				req.write = 1'b1;
				req.addr  = BEST_HOP_ADDR;
				req.wdata = best_idx;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state   <= S_IDLE;
			rd_wait <= 1'b0;
			i       <= '0;
		end else begin
			if (gnt && !req.write) begin
				rd_wait <= 1'b1;
			end else if (rvalid) begin
				rd_wait <= 1'b0;
			end
			case (state)
				S_IDLE: if (start) state <= S_NCNT;
				S_NCNT: begin
					if (rvalid) begin
						i     <= '0;
						state <= (rdata == '0) ? S_WR : S_Q; // write 0 when no neighbors
					end
				end
				S_Q: begin
					if (rvalid) begin
						if (i + word_t'(1) == ncnt) begin
							state <= S_WR;
						end else begin
							i <= i + word_t'(1);
						end
					end
				end
				S_WR:    if (gnt) state <= S_DONE;
				S_DONE:  state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rvalid && state == S_NCNT) begin
			ncnt     <= rdata;
			best_idx <= '0;
		end
		if (rvalid && state == S_Q && (i == '0 || rdata < best_q)) begin
			best_q   <= rdata; // strict compare keeps lower index on tie
			best_idx <= i;
		end
	end

endmodule

// ==== src/sink_list_fixer.sv ====
`timescale 1ns/100ps

module sink_list_fixer #(
	parameter int unsigned SINK_SLOTS = 8
) (
	input  logic                  clock,
	input  logic                  nrst,
	input  logic                  start,
	output routing_pkg::mem_req_t req,
	input  logic                  gnt,
	input  logic                  rvalid,
	input  routing_pkg::word_t    rdata,
	output logic                  done
);
	import routing_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_NCNT,
		S_SCNT,
		S_SINK,
		S_ROWCNT,
		S_ID,
		S_WR_ID,
		S_HOPS,
		S_Q,
		S_WR_Q,
		S_WR_CNT,
		S_NEXT,
		S_DONE
	} fix_state_t;

	fix_state_t state;
	logic       rd_wait; // read granted but data not back yet
	logic       is_rd;
	logic       is_wr;
	word_t      i; // neighbor index
	word_t      j; // known sink index
	word_t      k; // slot index within row
	word_t      ncnt;
	word_t      scnt;
	word_t      sink;
	word_t      rcnt; // current row count
	word_t      hops;
	word_t      q_sum;

	assign is_rd = state inside {S_NCNT, S_SCNT, S_SINK, S_ROWCNT, S_ID, S_HOPS, S_Q};
	assign is_wr = state inside {S_WR_ID, S_WR_Q, S_WR_CNT};
	assign done  = (state == S_DONE);

	always_comb begin
		req = REQ_IDLE;
		case (state)
			S_NCNT:   req.addr = NEIGHBOR_COUNT_ADDR;
			S_SCNT:   req.addr = KNOWN_SINK_COUNT_ADDR;
			S_SINK:   req.addr = table_addr(KNOWN_SINKS_BASE, j);
			S_ROWCNT: req.addr = table_addr(SINK_ID_COUNT_BASE, i);
			S_ID:     req.addr = table_addr(SINK_IDS_BASE, word_t'(i * SINK_SLOTS + k));
			S_HOPS:   req.addr = table_addr(WORST_HOPS_BASE, j);
			S_Q:      req.addr = table_addr(Q_VALUE_BASE, i);
			S_WR_ID: begin
				req.addr  = table_addr(SINK_IDS_BASE, word_t'(i * SINK_SLOTS + rcnt));
				req.wdata = sink; // append at slot count
			end
			S_WR_Q: begin
				req.addr  = table_addr(Q_VALUE_BASE, i);
				req.wdata = q_sum;
			end
			S_WR_CNT: begin
				req.addr  = table_addr(SINK_ID_COUNT_BASE, i);
				req.wdata = rcnt + word_t'(1);
			end
			default: ;
		endcase
		req.write = is_wr;
		req.valid = is_wr || (is_rd && !rd_wait); // held until granted
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state   <= S_IDLE;
			rd_wait <= 1'b0;
			i       <= '0;
			j       <= '0;
			k       <= '0;
		end else begin
			if (gnt && !req.write) begin
				rd_wait <= 1'b1;
			end else if (rvalid) begin
				rd_wait <= 1'b0;
			end
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_NCNT;
						i     <= '0;
						j     <= '0;
					end
				end
				S_NCNT: if (rvalid) state <= S_SCNT;
				S_SCNT: begin
					if (rvalid) begin
						state <= (rdata == '0 || ncnt == '0) ? S_DONE : S_SINK;
					end
				end
				S_SINK: if (rvalid) state <= S_ROWCNT;
				S_ROWCNT: begin
					if (rvalid) begin
						k     <= '0;
						state <= (rdata == '0) ? S_WR_ID : S_ID; // empty row
					end
				end
				S_ID: begin
					if (rvalid) begin
						if (rdata == sink) begin
							state <= S_NEXT; // already listed
						end else if (k + word_t'(1) == rcnt) begin
							state <= (rcnt < SINK_SLOTS) ? S_WR_ID : S_NEXT;
						end else begin
							k <= k + word_t'(1);
						end
					end
				end
				S_WR_ID:  if (gnt) state <= S_HOPS;
				S_HOPS:   if (rvalid) state <= S_Q;
				S_Q:      if (rvalid) state <= S_WR_Q;
				S_WR_Q:   if (gnt) state <= S_WR_CNT;
				S_WR_CNT: if (gnt) state <= S_NEXT;
				S_NEXT: begin
					if (i + word_t'(1) == ncnt) begin
						i <= '0;
						if (j + word_t'(1) == scnt) begin
							state <= S_DONE;
						end else begin
							j     <= j + word_t'(1);
							state <= S_SINK;
						end
					end else begin
						i     <= i + word_t'(1);
						state <= S_ROWCNT; // same sink with the next neighbor
					end
				end
				S_DONE:  state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rvalid) begin
			case (state)
				S_NCNT:   ncnt  <= rdata;
				S_SCNT:   scnt  <= rdata;
				S_SINK:   sink  <= rdata;
				S_ROWCNT: rcnt  <= rdata;
				S_HOPS:   hops  <= rdata;
				S_Q:      q_sum <= rdata + hops + word_t'(1);
				default: ;
			endcase
		end
	end

endmodule

// ==== src/table_arbiter.sv ====
`timescale 1ns/100ps

module table_arbiter (
	input  logic                  clock,
	input  logic                  nrst,
	input  routing_pkg::mem_req_t host_req,
	input  routing_pkg::mem_req_t fix_req,
	input  routing_pkg::mem_req_t sel_req,
	output logic                  fix_gnt,
	output logic                  sel_gnt,
	output logic                  fix_rvalid,
	output logic                  sel_rvalid,
	output routing_pkg::mem_req_t mem_req
);
	import routing_pkg::*;

	logic last_sel; // selector was the last engine granted

	// host always wins and engines alternate when both wait
	always_comb begin
		fix_gnt = 1'b0;
		sel_gnt = 1'b0;
		if (!host_req.valid) begin
			if (fix_req.valid && sel_req.valid) begin
				fix_gnt = last_sel;
				sel_gnt = !last_sel;
			end else begin
				fix_gnt = fix_req.valid;
				sel_gnt = sel_req.valid;
			end
		end
	end

	always_comb begin
		if (host_req.valid) begin
			mem_req = host_req;
		end else if (fix_gnt) begin
			mem_req = fix_req;
		end else if (sel_gnt) begin
			mem_req = sel_req;
		end else begin
			mem_req = REQ_IDLE;
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			last_sel   <= 1'b0;
			fix_rvalid <= 1'b0;
			sel_rvalid <= 1'b0;
		end else begin
			if (fix_gnt) begin
				last_sel <= 1'b0;
			end else if (sel_gnt) begin
				last_sel <= 1'b1;
			end
			fix_rvalid <= fix_gnt && !fix_req.write; // read owner for next cycle
			sel_rvalid <= sel_gnt && !sel_req.write;
		end
	end

endmodule

// ==== src/table_memory.sv ====
`timescale 1ns/100ps

module table_memory #(
	parameter int MEM_WORDS = 1024
) (
	input  logic                clock,
	input  routing_pkg::mem_req_t req,
	output routing_pkg::word_t    rdata
);
	import routing_pkg::*;

	localparam int IDX_WIDTH = $clog2(MEM_WORDS);

	word_t                 mem [MEM_WORDS];
	logic  [IDX_WIDTH-1:0] idx;

	assign idx = req.addr[IDX_WIDTH:1]; // word index without the byte bit

	always_ff @(posedge clock) begin
		if (req.valid) begin
			if (req.write) begin
				mem[idx] <= req.wdata;
			end
			rdata <= mem[idx]; // old word on a write cycle
		end
	end

endmodule

// ==== src/routing_pkg.sv ====
package routing_pkg;

	localparam int ADDR_WIDTH = 11;
	localparam int WORD_WIDTH = 16;

	typedef logic [ADDR_WIDTH-1:0] addr_t; // byte address with bit 0 always zero
	typedef logic [WORD_WIDTH-1:0] word_t;

	typedef struct packed {
		logic  valid;
		logic  write;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	localparam mem_req_t REQ_IDLE = '0;

	// routing table layout
	localparam addr_t KNOWN_SINKS_BASE      = 11'h008;
	localparam addr_t WORST_HOPS_BASE       = 11'h028;
	localparam addr_t Q_VALUE_BASE          = 11'h1C8;
	localparam addr_t SINK_IDS_BASE         = 11'h248; // rows of SINK_SLOTS words
	localparam addr_t KNOWN_SINK_COUNT_ADDR = 11'h688;
	localparam addr_t NEIGHBOR_COUNT_ADDR   = 11'h68A;
	localparam addr_t SINK_ID_COUNT_BASE    = 11'h68E;
	localparam addr_t BEST_HOP_ADDR         = 11'h6C0;

	// byte address of word index within a table
	function automatic addr_t table_addr(addr_t base, word_t index);
		addr_t offset;
		offset = addr_t'({index, 1'b0});
		return base + offset;
	endfunction

endpackage
